//--- build.f
+incdir+.
icache_pkg.sv
icache_ctrl.sv
icache_store.sv
access_counter.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_icache \
    -Mdir obj_dir -o sim_icache

./obj_dir/sim_icache

//--- icache_input.txt
# M <byte addr hex> <word hex> | R <byte addr hex> | F
# C <expected hits dec> <expected misses dec>
M 0000 13000093
M 0004 00100113
M 0008 00208193
M 003C 0ff00213
M 0040 deadbeef
M 1000 cafef00d
M 0104 12345678
M FFFC 0badc0de
R 0000
R 0002
R 0004
R 0004
C 2 2
R 0040
R 0000
R 0040
R 1000
R 0000
C 2 7
R 003C
R FFFE
R 0104
R 0104
R 0008
R 0008
C 4 11
F
R 0104
R 0000
R 0001
C 5 13

//--- tb_icache.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_icache;

    localparam int LINES   = 1 << `ICACHE_INDEX_W;
    localparam int TIMEOUT = 50;

    logic               clk;
    logic               rst;
    logic               cpu_req_valid;
    icache_pkg::addr_t  cpu_req_addr;
    logic               flush;
    logic               mem_req_ready;
    icache_pkg::word_t  mem_rd_data;
    logic               cpu_req_ready;
    icache_pkg::word_t  cpu_rd_data;
    logic               mem_req_valid;
    icache_pkg::addr_t  mem_req_addr;
    icache_pkg::count_t hit_count;
    icache_pkg::count_t miss_count;
    int unsigned        answered;

    // reference model of the cache contents
    logic [LINES-1:0]   ref_valid;
    icache_pkg::tag_t   ref_tag [LINES];
    int unsigned        ref_hits;
    int unsigned        ref_misses;
    icache_pkg::word_t  image [int];

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    icache_top uut (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .flush         (flush),
        .mem_req_ready (mem_req_ready),
        .mem_rd_data   (mem_rd_data),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rd_data   (cpu_rd_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    tb_mem_model mem_model (
        .clk           (clk),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rd_data   (mem_rd_data),
        .answered      (answered)
    );

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic fetch(input icache_pkg::addr_t addr);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   tag;
        icache_pkg::addr_t  aligned;
        logic               predict_hit;
        logic               mem_seen;
        logic               mem_done;
        logic               done;
        int unsigned        answered_before;
        int                 cycles;
        idx         = addr[`ICACHE_INDEX_W+1:2];
        tag         = addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+2];
        aligned     = {addr[`ICACHE_ADDR_W-1:2], 2'b00};
        predict_hit = ref_valid[idx] && (ref_tag[idx] == tag);
        if (!image.exists(int'(addr[`ICACHE_ADDR_W-1:2])))
            abort_run($sformatf("fetch address %h is not in the memory image", addr));
        @(negedge clk);
        answered_before = answered;
        cpu_req_addr    = addr;
        cpu_req_valid   = 1'b1;
        cycles          = 0;
        mem_seen        = 1'b0;
        mem_done        = 1'b0;
        done            = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("timeout: no cpu_req_ready for fetch of %h", addr));
            if (mem_req_valid)
            begin
                if (mem_done)
                    abort_run("mem_req_valid rose twice for one fetch");
                compare_value("mem_req_addr", mem_req_addr, aligned);
                mem_seen = 1'b1;
            end
            else if (mem_seen && !mem_done)
            begin
                // valid may only drop after memory answered once
                mem_done = 1'b1;
                compare_value("memory answers", answered, answered_before + 1);
            end
            if (cpu_req_ready)
            begin
                done = 1'b1;
                compare_value("cpu_rd_data", cpu_rd_data,
                              image[int'(addr[`ICACHE_ADDR_W-1:2])]);
            end
        end
        cpu_req_valid = 1'b0;
        if (predict_hit)
        begin
            compare_value("hit latency", cycles, 1);
            compare_value("mem_req_valid on hit", mem_seen, 0);
            ref_hits++;
        end
        else
        begin
            compare_value("mem_req_valid on miss", mem_seen, 1);
            compare_value("refill done", mem_done, 1);
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
            ref_misses++;
        end
    endtask

    task automatic pulse_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        ref_valid = '0;
    endtask

    task automatic check_counters(input int unsigned hits, input int unsigned misses);
        @(negedge clk);
        compare_value("model hit count", ref_hits, hits);
        compare_value("model miss count", ref_misses, misses);
        compare_value("hit_count", hit_count, ref_hits);
        compare_value("miss_count", miss_count, ref_misses);
    endtask

    task automatic run_input_file();
        int          fd;
        int          n;
        int          line_no;
        string       text;
        byte         cmd;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("icache_input.txt", "r");
        if (fd == 0)
            abort_run("cannot open icache_input.txt");
        line_no = 0;
        while (!$feof(fd))
        begin
            text = "";
            n    = $fgets(text, fd);
            line_no++;
            if (text.len() > 0)
            begin
                cmd = text.getc(0);
                case (cmd)
                    "M":
                    begin
                        n = $sscanf(text.substr(1, text.len() - 1), "%h %h", a, b);
                        if (n != 2)
                            abort_run($sformatf("bad memory line %0d in input file", line_no));
                        image[int'(a[`ICACHE_ADDR_W-1:2])] = b;
                        mem_model.write_word(a[`ICACHE_ADDR_W-1:0], b);
                    end
                    "R":
                    begin
                        n = $sscanf(text.substr(1, text.len() - 1), "%h", a);
                        if (n != 1)
                            abort_run($sformatf("bad fetch line %0d in input file", line_no));
                        fetch(a[`ICACHE_ADDR_W-1:0]);
                    end
                    "F": pulse_flush();
                    "C":
                    begin
                        n = $sscanf(text.substr(1, text.len() - 1), "%d %d", a, b);
                        if (n != 2)
                            abort_run($sformatf("bad counter line %0d in input file", line_no));
                        check_counters(a, b);
                    end
                    "#", "\n", "\r", " ": ;
                    default: abort_run($sformatf("unknown command on line %0d", line_no));
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_addr  = '0;
        flush         = 1'b0;
        ref_valid     = '0;
        ref_hits      = 0;
        ref_misses    = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_value("cpu_req_ready", cpu_req_ready, 0);
        compare_value("mem_req_valid", mem_req_valid, 0);
        compare_value("hit_count", hit_count, 0);
        compare_value("miss_count", miss_count, 0);
        run_input_file();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_mem_model (
    input  logic              clk,
    input  logic              mem_req_valid,
    input  icache_pkg::addr_t mem_req_addr,
    output logic              mem_req_ready,
    output icache_pkg::word_t mem_rd_data,
    output int unsigned       answered
);

    localparam int WORDS = 1 << (`ICACHE_ADDR_W - 2);

    icache_pkg::word_t mem [WORDS];
    integer            seed;
    int                delay;

    // fill carries the whole word address so a wrong read shows up
    initial
    begin
        for (int i = 0; i < WORDS; i++)
            mem[i] = 32'hbad00000 | 32'(i);
    end

    task automatic write_word(input icache_pkg::addr_t addr, input icache_pkg::word_t data);
        mem[addr[`ICACHE_ADDR_W-1:2]] = data;
    endtask

    initial
    begin
        seed          = 76;
        mem_req_ready = 1'b0;
        mem_rd_data   = '0;
        answered      = 0;
        forever
        begin
            @(negedge clk);
            if (mem_req_valid)
            begin
                // 1 to 4 cycles before the answer
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                mem_req_ready = 1'b1;
                mem_rd_data   = mem[mem_req_addr[`ICACHE_ADDR_W-1:2]];
                answered      = answered + 1;
                @(negedge clk);
                mem_req_ready = 1'b0;
            end
        end
    end

endmodule

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req_valid,
    input  icache_pkg::addr_t  cpu_req_addr,
    input  logic               flush,
    input  logic               mem_req_ready,
    input  icache_pkg::word_t  mem_rd_data,
    output logic               cpu_req_ready,
    output icache_pkg::word_t  cpu_rd_data,
    output logic               mem_req_valid,
    output icache_pkg::addr_t  mem_req_addr,
    output icache_pkg::count_t hit_count,
    output icache_pkg::count_t miss_count
);

    icache_pkg::lookup_t  lookup;
    icache_pkg::line_wr_t line_wr;
    icache_pkg::word_t    rd_data;
    logic                 hit;
    logic                 inv_all;
    logic                 hit_evt;
    logic                 miss_evt;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .flush         (flush),
        .hit           (hit),
        .rd_data       (rd_data),
        .mem_req_ready (mem_req_ready),
        .mem_rd_data   (mem_rd_data),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rd_data   (cpu_rd_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .lookup        (lookup),
        .line_wr       (line_wr),
        .inv_all       (inv_all),
        .hit_evt       (hit_evt),
        .miss_evt      (miss_evt)
    );

    icache_store u_store (
        .clk     (clk),
        .rst     (rst),
        .lookup  (lookup),
        .line_wr (line_wr),
        .inv_all (inv_all),
        .hit     (hit),
        .rd_data (rd_data)
    );

    // event counts exposed for the fetch side
    access_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .hit_evt    (hit_evt),
        .miss_evt   (miss_evt),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

//--- access_counter.sv
`timescale 1ns/1ps

module access_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               hit_evt,
    input  logic               miss_evt,
    output icache_pkg::count_t hit_count,
    output icache_pkg::count_t miss_count
);

    // sticks at all ones once full
    function automatic icache_pkg::count_t sat_inc(input icache_pkg::count_t cnt,
                                                   input logic evt);
        icache_pkg::count_t res;
        res = cnt;
        if (evt && (cnt != '1))
            res = cnt + 1'b1;
        return res;
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else
        begin
            hit_count  <= sat_inc(hit_count, hit_evt);
            miss_count <= sat_inc(miss_count, miss_evt);
        end
    end

endmodule

//--- icache_store.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_store (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::lookup_t  lookup,
    input  icache_pkg::line_wr_t line_wr,
    input  logic                 inv_all,
    output logic                 hit,
    output icache_pkg::word_t    rd_data
);

    localparam int LINES = 1 << `ICACHE_INDEX_W;

    logic [LINES-1:0]   valid;
    icache_pkg::tag_t   tag_mem  [LINES];
    icache_pkg::word_t  data_mem [LINES];

    // valid bits, cleared on reset or flush
    always_ff @(posedge clk)
    begin
        if (rst || inv_all)
        begin
            valid <= '0;
        end
        else if (line_wr.we)
        begin
            valid[line_wr.index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk)
    begin
        if (line_wr.we)
        begin
            tag_mem[line_wr.index]  <= line_wr.tag;
            data_mem[line_wr.index] <= line_wr.data;
        end
    end

    // combinational compare on the latched request
    always_comb
    begin
        hit     = valid[lookup.index] && (tag_mem[lookup.index] == lookup.tag);
        rd_data = data_mem[lookup.index];
    end

endmodule

//--- icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_req_valid,
    input  icache_pkg::addr_t   cpu_req_addr,
    input  logic                flush,
    input  logic                hit,
    input  icache_pkg::word_t   rd_data,
    input  logic                mem_req_ready,
    input  icache_pkg::word_t   mem_rd_data,
    output logic                cpu_req_ready,
    output icache_pkg::word_t   cpu_rd_data,
    output logic                mem_req_valid,
    output icache_pkg::addr_t   mem_req_addr,
    output icache_pkg::lookup_t lookup,
    output icache_pkg::line_wr_t line_wr,
    output logic                inv_all,
    output logic                hit_evt,
    output logic                miss_evt
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_nxt;
    icache_pkg::addr_t       req_addr;
    logic                    retry;
    logic                    accept;
    logic                    refill_done;

    // flush wins over a request in the same cycle
    assign inv_all     = (state == icache_pkg::ST_IDLE) && flush;
    assign accept      = (state == icache_pkg::ST_IDLE) && !flush && cpu_req_valid;
    assign refill_done = (state == icache_pkg::ST_REFILL) && mem_req_ready;

    assign lookup.index = req_addr[`ICACHE_INDEX_W+1:2];
    assign lookup.tag   = req_addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+2];

    assign cpu_req_ready = (state == icache_pkg::ST_LOOKUP) && hit;
    assign cpu_rd_data   = rd_data;

    // lookup after a refill is not a second event
    assign hit_evt  = cpu_req_ready && !retry;
    assign miss_evt = (state == icache_pkg::ST_LOOKUP) && !hit;

    assign line_wr.we    = refill_done;
    assign line_wr.index = lookup.index;
    assign line_wr.tag   = lookup.tag;
    assign line_wr.data  = mem_rd_data;

    always_comb
    begin
        state_nxt = state;
        case (state)
            icache_pkg::ST_IDLE:   if (accept) state_nxt = icache_pkg::ST_LOOKUP;
            icache_pkg::ST_LOOKUP: state_nxt = hit ? icache_pkg::ST_IDLE : icache_pkg::ST_REFILL;
            icache_pkg::ST_REFILL: if (mem_req_ready) state_nxt = icache_pkg::ST_LOOKUP;
            default:               state_nxt = icache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= icache_pkg::ST_IDLE;
            retry         <= 1'b0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (accept)
                retry <= 1'b0;
            else if (refill_done)
                retry <= 1'b1;
            // held until memory answers
            if (miss_evt)
                mem_req_valid <= 1'b1;
            else if (refill_done)
                mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= cpu_req_addr;
        if (miss_evt)
            mem_req_addr <= {req_addr[`ICACHE_ADDR_W-1:2], 2'b00};
    end

endmodule

//--- icache_pkg.sv
package icache_pkg;

    `include "icache_config.svh"

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]  word_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_COUNT_W-1:0] count_t;

    // latched request as seen by the store
    typedef struct packed {
        index_t index;
        tag_t   tag;
    } lookup_t;

    // refill of one line
    typedef struct packed {
        logic   we;
        index_t index;
        tag_t   tag;
        word_t  data;
    } line_wr_t;

    typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_REFILL} ctrl_state_t;

endpackage

//--- icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// byte address into instruction memory
`define ICACHE_ADDR_W 16

// 16 lines, one word each
`define ICACHE_INDEX_W 4

`define ICACHE_WORD_W 32

`define ICACHE_COUNT_W 16

// two low bits select the byte within a word
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - 2)

`endif
